/* hdl/cjtag_bridge.sv */
// cJTAG to JTAG bridge top level
`timescale 1ns/1ps

module cjtag_bridge (
    input  logic clk_i,         // System clock, samples the probe pins
    input  logic ntrst_i,       // Asynchronous reset, active low

    // Two-pin probe side
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tmsc_o,
    output logic tmsc_oen_o,    // 0 while the bridge drives TMSC

    // Four-pin target side
    output logic tck_o,
    output logic tms_o,
    output logic tdi_o,
    input  logic tdo_i,

    // Status
    output logic online_o,      // Link in OScan1
    output logic nsp_o          // Standard protocol indicator
);

    import cjtag_link_pkg::*;

    esc_kind_t   esc_kind;
    link_state_t link_state;
    logic        esc_valid;
    logic        bit_fall;

    cjtag_edge_if edges ();     // Sampled levels and edge pulses

    // ======================================================================
    // Sampling and event detection
    // ======================================================================
    cjtag_edge_detect u_edge_detect (
        .clk_i   (clk_i),
        .ntrst_i (ntrst_i),
        .tckc_i  (tckc_i),
        .tmsc_i  (tmsc_i),
        .edges   (edges.src)
    );

    cjtag_escape_detect u_escape_detect (
        .clk_i       (clk_i),
        .ntrst_i     (ntrst_i),
        .edges       (edges.esc),
        .esc_valid_o (esc_valid),
        .esc_kind_o  (esc_kind),
        .bit_fall_o  (bit_fall)
    );

    // ======================================================================
    // Link control and JTAG generation
    // ======================================================================
    cjtag_link_fsm u_link_fsm (
        .clk_i        (clk_i),
        .ntrst_i      (ntrst_i),
        .esc_valid_i  (esc_valid),
        .esc_kind_i   (esc_kind),
        .bit_fall_i   (bit_fall),
        .tmsc_s_i     (edges.tmsc_s),
        .link_state_o (link_state)
    );

    oscan1_packet u_oscan1_packet (
        .clk_i        (clk_i),
        .ntrst_i      (ntrst_i),
        .edges        (edges.scan),
        .bit_fall_i   (bit_fall),
        .link_state_i (link_state),
        .tdo_i        (tdo_i),
        .tck_o        (tck_o),
        .tms_o        (tms_o),
        .tdi_o        (tdi_o),
        .tmsc_o       (tmsc_o),
        .tmsc_oen_o   (tmsc_oen_o),
        .online_o     (online_o),
        .nsp_o        (nsp_o)
    );

endmodule

/* hdl/cjtag_config.svh */
// cJTAG bridge configuration
`ifndef CJTAG_CONFIG_SVH
`define CJTAG_CONFIG_SVH

// ======================================================================
// Input sampling
// ======================================================================
`define CJTAG_SYNC_STAGES    2        // Default synchronizer depth

// ======================================================================
// Escape detection
// ======================================================================
`define CJTAG_MIN_ESC_CYCLES 20       // TCKC high clocks needed for an escape
`define CJTAG_CNT_W          5        // High-time and toggle counter width
`define CJTAG_SEL_MIN        6        // Selection escape, lowest toggle count
`define CJTAG_SEL_MAX        7        // Selection escape, highest toggle count
`define CJTAG_RESET_MIN      8        // Reset escape from here upwards

// Online activation code
`define CJTAG_OAC_W          4
`define CJTAG_OAC_VALUE      4'b1011  // Arrives LSB first as 1,1,0,1

// ======================================================================
// JTAG pin idle levels
// ======================================================================
`define CJTAG_TMS_IDLE       1'b1     // Keeps the TAP parked

`endif

/* hdl/cjtag_edge_detect.sv */
// cJTAG input synchronizer and edge detector
`timescale 1ns/1ps
`include "cjtag_config.svh"

module cjtag_edge_detect #(
    parameter int SYNC_STAGES = `CJTAG_SYNC_STAGES   // At least 2
) (
    input  logic         clk_i,
    input  logic         ntrst_i,
    input  logic         tckc_i,        // Asynchronous probe clock
    input  logic         tmsc_i,        // Asynchronous probe data
    cjtag_edge_if.src    edges
);

    logic [SYNC_STAGES-1:0] tckc_sync;   // Shift chain, MSB is the safe end
    logic [SYNC_STAGES-1:0] tmsc_sync;
    logic                   tckc_prev;   // Level from the previous clock
    logic                   tmsc_prev;

    // ======================================================================
    // Synchronizers
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_sync <= '0;
            tmsc_sync <= '0;
        end else begin
            tckc_sync <= {tckc_sync[SYNC_STAGES-2:0], tckc_i};
            tmsc_sync <= {tmsc_sync[SYNC_STAGES-2:0], tmsc_i};
        end
    end

    assign edges.tckc_s = tckc_sync[SYNC_STAGES-1];
    assign edges.tmsc_s = tmsc_sync[SYNC_STAGES-1];

    // ======================================================================
    // Edge pulses, one register after the synchronized level
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_prev         <= 1'b0;
            tmsc_prev         <= 1'b0;
            edges.tckc_rise   <= 1'b0;
            edges.tckc_fall   <= 1'b0;
            edges.tmsc_toggle <= 1'b0;
        end else begin
            tckc_prev         <= edges.tckc_s;
            tmsc_prev         <= edges.tmsc_s;
            edges.tckc_rise   <= !tckc_prev && edges.tckc_s;
            edges.tckc_fall   <= tckc_prev && !edges.tckc_s;
            edges.tmsc_toggle <= tmsc_prev != edges.tmsc_s;    // Either direction
        end
    end

endmodule

/* hdl/cjtag_edge_if.sv */
// cJTAG sampled levels and edges
`timescale 1ns/1ps

interface cjtag_edge_if;

    logic tckc_s;           // Synchronized TCKC level
    logic tmsc_s;           // Synchronized TMSC level
    logic tckc_rise;        // One clock pulse per TCKC rise
    logic tckc_fall;        // One clock pulse per TCKC fall
    logic tmsc_toggle;      // One clock pulse per TMSC change

    // Edge detector side
    modport src (
        output tckc_s, tmsc_s, tckc_rise, tckc_fall, tmsc_toggle
    );

    // Escape detector only needs TCKC timing and TMSC activity
    modport esc (
        input tckc_s, tckc_rise, tckc_fall, tmsc_toggle
    );

    // Packet engine samples data and reacts to rises
    modport scan (
        input tmsc_s, tckc_rise
    );

endinterface

/* hdl/cjtag_escape_detect.sv */
// cJTAG escape sequence detector
`timescale 1ns/1ps
`include "cjtag_config.svh"

module cjtag_escape_detect (
    input  logic                     clk_i,
    input  logic                     ntrst_i,
    cjtag_edge_if.esc                edges,
    output logic                     esc_valid_o,   // Fall that ended an escape
    output cjtag_link_pkg::esc_kind_t esc_kind_o,   // Class of that escape
    output logic                     bit_fall_o     // Ordinary data clock fall
);

    import cjtag_link_pkg::*;

    localparam esc_cnt_t MIN_ESC   = esc_cnt_t'(`CJTAG_MIN_ESC_CYCLES);
    localparam esc_cnt_t SEL_MIN   = esc_cnt_t'(`CJTAG_SEL_MIN);
    localparam esc_cnt_t SEL_MAX   = esc_cnt_t'(`CJTAG_SEL_MAX);
    localparam esc_cnt_t RESET_MIN = esc_cnt_t'(`CJTAG_RESET_MIN);

    esc_cnt_t  high_cnt;        // Clocks since the last TCKC rise
    esc_cnt_t  tgl_cnt;         // TMSC changes while TCKC high
    esc_kind_t kind_d;          // Class of the sequence in progress
    logic      is_esc;          // High time long enough for an escape

    // ======================================================================
    // High-time and toggle counters
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            high_cnt <= '0;
            tgl_cnt  <= '0;
        end else if (edges.tckc_rise) begin
            high_cnt <= esc_cnt_t'(1);      // Rise is the first high clock
            tgl_cnt  <= '0;
        end else if (edges.tckc_fall) begin
            high_cnt <= '0;                 // Held until now for the classifier
        end else if (edges.tckc_s) begin
            if (high_cnt != '1) high_cnt <= high_cnt + esc_cnt_t'(1);  // Saturate
            if (edges.tmsc_toggle && tgl_cnt != '1) begin
                tgl_cnt <= tgl_cnt + esc_cnt_t'(1);
            end
        end
    end

    // Sort the toggle count, 4 and 5 toggles land in OTHER
    always_comb begin
        if (tgl_cnt >= RESET_MIN) begin
            kind_d = ESC_RESET;
        end else if (tgl_cnt >= SEL_MIN && tgl_cnt <= SEL_MAX) begin
            kind_d = ESC_SELECT;
        end else begin
            kind_d = ESC_OTHER;
        end
    end

    assign is_esc = high_cnt >= MIN_ESC;

    // ======================================================================
    // Registered fall events, exactly one of them per TCKC fall
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            esc_valid_o <= 1'b0;
            bit_fall_o  <= 1'b0;
        end else begin
            esc_valid_o <= edges.tckc_fall && is_esc;
            bit_fall_o  <= edges.tckc_fall && !is_esc;     // Short high time
        end
    end

    // Kind is only looked at together with esc_valid_o
    always_ff @(posedge clk_i) begin
        if (edges.tckc_fall) esc_kind_o <= kind_d;
    end

endmodule

/* hdl/cjtag_link_fsm.sv */
// cJTAG link state machine
`timescale 1ns/1ps
`include "cjtag_config.svh"

module cjtag_link_fsm (
    input  logic                        clk_i,
    input  logic                        ntrst_i,
    input  logic                        esc_valid_i,    // Escape ended on this clock
    input  cjtag_link_pkg::esc_kind_t   esc_kind_i,
    input  logic                        bit_fall_i,     // Normal TCKC fall
    input  logic                        tmsc_s_i,       // Synchronized TMSC
    output cjtag_link_pkg::link_state_t link_state_o
);

    import cjtag_link_pkg::*;

    localparam int   OAC_CNT_W = $clog2(`CJTAG_OAC_W);
    localparam oac_t OAC_VALUE = `CJTAG_OAC_VALUE;

    logic [OAC_CNT_W-1:0] oac_cnt;     // OAC bits taken so far
    oac_t                 oac_sr;      // OAC shift register, fills from the top
    oac_t                 oac_word;    // Word including the bit on TMSC now

    // Newest bit enters at the MSB, so the first bit ends at bit 0
    assign oac_word = {tmsc_s_i, oac_sr[`CJTAG_OAC_W-1:1]};

    // ======================================================================
    // State register
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            link_state_o <= LINK_OFFLINE;
            oac_cnt      <= '0;
        end else if (esc_valid_i && esc_kind_i == ESC_RESET) begin
            link_state_o <= LINK_OFFLINE;      // Reset escape wins everywhere
        end else begin
            case (link_state_o)
                LINK_OFFLINE: begin
                    if (esc_valid_i && esc_kind_i == ESC_SELECT) begin
                        link_state_o <= LINK_ONLINE_ACT;
                        oac_cnt      <= '0;
                    end
                end
                LINK_ONLINE_ACT: begin
                    if (bit_fall_i) begin
                        oac_cnt <= oac_cnt + 1'b1;
                        if (oac_cnt == OAC_CNT_W'(`CJTAG_OAC_W - 1)) begin
                            // Last bit, accept only the exact code
                            link_state_o <= (oac_word == OAC_VALUE) ? LINK_OSCAN1
                                                                    : LINK_OFFLINE;
                        end
                    end
                end
                LINK_OSCAN1: begin
                    link_state_o <= LINK_OSCAN1;       // Left only by reset escape
                end
                default: begin
                    link_state_o <= LINK_OFFLINE;
                end
            endcase
        end
    end

    // ======================================================================
    // OAC capture, LSB first on each bit fall
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (link_state_o == LINK_ONLINE_ACT && bit_fall_i) begin
            oac_sr <= oac_word;
        end
    end

endmodule

/* hdl/cjtag_link_pkg.sv */
// cJTAG link layer types
`include "cjtag_config.svh"

package cjtag_link_pkg;

    // ======================================================================
    // Link state
    // ======================================================================
    typedef enum logic [1:0] {
        LINK_OFFLINE    = 2'd0,     // Waiting for a selection escape
        LINK_ONLINE_ACT = 2'd1,     // Receiving the activation code
        LINK_OSCAN1     = 2'd2      // Running 3-bit scan packets
    } link_state_t;

    // ======================================================================
    // Escape classification
    // ======================================================================
    // Deselection toggle counts fall into the OTHER class
    typedef enum logic [1:0] {
        ESC_OTHER  = 2'd0,          // Ignored by the link
        ESC_SELECT = 2'd1,          // 6 or 7 toggles
        ESC_RESET  = 2'd2           // 8 or more toggles
    } esc_kind_t;

    // Counter for TMSC toggles and TCKC high time
    typedef logic [`CJTAG_CNT_W-1:0] esc_cnt_t;

    // Online activation code word
    typedef logic [`CJTAG_OAC_W-1:0] oac_t;

endpackage

/* hdl/oscan1_packet.sv */
// OScan1 packet engine and JTAG pin driver
`timescale 1ns/1ps
`include "cjtag_config.svh"

module oscan1_packet (
    input  logic                        clk_i,
    input  logic                        ntrst_i,
    cjtag_edge_if.scan                  edges,
    input  logic                        bit_fall_i,     // Normal TCKC fall
    input  cjtag_link_pkg::link_state_t link_state_i,
    input  logic                        tdo_i,          // From the target TAP
    output logic                        tck_o,
    output logic                        tms_o,
    output logic                        tdi_o,
    output logic                        tmsc_o,         // TDO sent back to the probe
    output logic                        tmsc_oen_o,     // 0 drives TMSC, 1 listens
    output logic                        online_o,
    output logic                        nsp_o
);

    import cjtag_link_pkg::*;
    import oscan1_pkg::*;

    scan_pos_t pos;         // Slot that the next fall completes
    logic      tmsc_lat;    // TMSC taken on the last bit fall
    logic      in_scan;

    assign in_scan = link_state_i == LINK_OSCAN1;

    // ======================================================================
    // Position tracking and pin updates
    // ======================================================================
    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            pos        <= POS_NTDI;
            tck_o      <= 1'b0;
            tms_o      <= `CJTAG_TMS_IDLE;
            tdi_o      <= 1'b0;
            tmsc_oen_o <= 1'b1;
        end else if (!in_scan) begin
            pos        <= POS_NTDI;            // Idle pins until scanning
            tck_o      <= 1'b0;
            tms_o      <= `CJTAG_TMS_IDLE;
            tdi_o      <= 1'b0;
            tmsc_oen_o <= 1'b1;
        end else begin
            if (edges.tckc_rise) begin
                case (pos)
                    POS_TMS:  tdi_o <= ~tmsc_lat;      // nTDI came in inverted
                    POS_TDO: begin
                        tms_o      <= tmsc_lat;
                        tck_o      <= 1'b1;            // One TCK per packet
                        tmsc_oen_o <= 1'b0;            // Turn TMSC around
                    end
                    default:  tmsc_oen_o <= 1'b1;      // Release after TDO slot
                endcase
            end
            if (bit_fall_i) begin
                case (pos)
                    POS_NTDI: pos <= POS_TMS;
                    POS_TMS:  pos <= POS_TDO;
                    default:  pos <= POS_NTDI;
                endcase
                if (pos == POS_TDO) tck_o <= 1'b0;     // End of the TCK pulse
            end
        end
    end

    // Data bit captured on each fall in scan mode
    always_ff @(posedge clk_i) begin
        if (in_scan && bit_fall_i) tmsc_lat <= edges.tmsc_s;
    end

    // TDO passes straight through during its slot
    assign tmsc_o   = (in_scan && pos == POS_TDO) ? tdo_i : 1'b0;
    assign online_o = in_scan;
    assign nsp_o    = !in_scan;        // Standard protocol outside OScan1

endmodule

/* hdl/oscan1_pkg.sv */
// OScan1 packet types
package oscan1_pkg;

    // Bit position inside one 3-bit OScan1 packet
    // Order on the wire is nTDI, TMS, then TDO back from the target
    typedef enum logic [1:0] {
        POS_NTDI = 2'd0,    // Probe drives inverted TDI
        POS_TMS  = 2'd1,    // Probe drives TMS
        POS_TDO  = 2'd2     // Bridge drives TDO on TMSC
    } scan_pos_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cJTAG bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_cjtag_bridge \
    -f verilog.f

sim_out=$(./obj_dir/Vtb_cjtag_bridge)
echo "$sim_out"

# The run counts as passed only when the testbench printed its pass line
if grep -qx "TESTBENCH PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* verif/cjtag_checker.sv */
// cJTAG bridge response checker
`timescale 1ns/1ps
`include "cjtag_config.svh"

module cjtag_checker (
    input  logic       clk_i,
    // DUT outputs under watch
    input  logic       dut_tck_i,
    input  logic       dut_tms_i,
    input  logic       dut_tdi_i,
    input  logic       dut_tmsc_i,
    input  logic       dut_tmsc_oen_i,
    input  logic       dut_online_i,
    input  logic       dut_nsp_i,
    // Check requests from the stimulus side
    input  logic       req_i,           // One clock wide
    input  logic [2:0] kind_i,
    input  logic [7:0] arg_i,           // Test number or expected online level
    input  logic       ntdi_i,          // Packet fields being sent
    input  logic       tms_bit_i,
    input  logic       tdo_i,
    output int         tests_passed_o,
    output int         tests_failed_o
);

    localparam logic [2:0] K_TEST     = 3'd0;
    localparam logic [2:0] K_IDLE     = 3'd1;
    localparam logic [2:0] K_ONLINE   = 3'd2;
    localparam logic [2:0] K_SCAN_MID = 3'd3;
    localparam logic [2:0] K_SCAN_END = 3'd4;
    localparam logic [2:0] K_FINISH   = 3'd5;

    int   test_id   = 0;
    int   test_errs = 0;       // Mismatches in the running test
    int   n_pass    = 0;
    int   n_fail    = 0;
    logic in_test   = 1'b0;

    assign tests_passed_o = n_pass;
    assign tests_failed_o = n_fail;

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            test_errs++;
        end
    endtask

    // Report the running test, if any
    task automatic close_test();
        if (in_test) begin
            if (test_errs == 0) begin
                $display("test %0d passed", test_id);
                n_pass++;
            end else begin
                $display("test %0d failed with %0d mismatches", test_id, test_errs);
                n_fail++;
            end
        end
        in_test = 1'b0;
    endtask

    // ======================================================================
    // Predicted pin levels per request
    // ======================================================================
    always @(posedge clk_i) begin
        if (req_i) begin
            case (kind_i)
                K_TEST: begin
                    close_test();
                    test_id   = int'(arg_i);
                    test_errs = 0;
                    in_test   = 1'b1;
                end
                K_IDLE: begin                           // Levels of an offline link
                    compare_bit("tck_o", 1'b0, dut_tck_i);
                    compare_bit("tms_o", `CJTAG_TMS_IDLE, dut_tms_i);
                    compare_bit("tdi_o", 1'b0, dut_tdi_i);
                    compare_bit("tmsc_oen_o", 1'b1, dut_tmsc_oen_i);
                    compare_bit("online_o", 1'b0, dut_online_i);
                    compare_bit("nsp_o", 1'b1, dut_nsp_i);
                end
                K_ONLINE: begin
                    compare_bit("online_o", arg_i[0], dut_online_i);
                    compare_bit("nsp_o", !arg_i[0], dut_nsp_i);    // Always the inverse
                end
                K_SCAN_MID: begin                       // TCKC high in the TDO slot
                    compare_bit("tdi_o", ~ntdi_i, dut_tdi_i);
                    compare_bit("tms_o", tms_bit_i, dut_tms_i);
                    compare_bit("tck_o", 1'b1, dut_tck_i);
                    compare_bit("tmsc_oen_o", 1'b0, dut_tmsc_oen_i);
                    compare_bit("tmsc_o", tdo_i, dut_tmsc_i);
                end
                K_SCAN_END: compare_bit("tck_o", 1'b0, dut_tck_i);
                K_FINISH: begin
                    close_test();
                    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
                end
                default: ;
            endcase
        end
    end

endmodule

/* verif/cjtag_patterns.txt */
// Columns as hex bytes: cmd arg1 arg2 arg3. 01 test, 02 escape (toggles, high clocks),
// 03 OAC nibble, 04 packet (nTDI, TMS, TDO), 05 expected online, 06 idle pins, ff end
01010000  // Test 1, levels after reset
06000000
01020000  // Test 2, selection with 6 toggles then OAC
02061e00
030b0000
05010000
01030000  // Test 3, reset then selection with 7 toggles
02081e00
05000000
02071e00
030b0000
05010000
01040000  // Test 4, sequences that leave the link offline
02081e00
02061e00
03090000  // Wrong OAC
05000000
02041e00
05000000
02091e00
02060a00  // High time too short for an escape
05000000
01050000  // Test 5, OScan1 packets
02061e00
030b0000
04010101
04000100
04010000
01060000  // Test 6, escapes while scanning
02061e00
02051e00
05010000
04000001
02081e00
06000000
ff000000

/* verif/tb_cjtag_bridge.sv */
// cJTAG bridge testbench
`timescale 1ns/1ps
`include "cjtag_config.svh"

module tb_cjtag_bridge;

    localparam int MAX_CMDS     = 64;
    localparam int HALF_CLKS    = 12;      // TCKC half period of a data bit
    localparam int CLKS_PER_CMD = 400;     // Watchdog budget per pattern line

    // Pattern file command codes
    localparam logic [7:0] C_TEST   = 8'h01;
    localparam logic [7:0] C_ESCAPE = 8'h02;
    localparam logic [7:0] C_OAC    = 8'h03;
    localparam logic [7:0] C_PACKET = 8'h04;
    localparam logic [7:0] C_ONLINE = 8'h05;
    localparam logic [7:0] C_IDLE   = 8'h06;
    localparam logic [7:0] C_END    = 8'hff;

    // Checker request kinds
    localparam logic [2:0] K_TEST     = 3'd0;
    localparam logic [2:0] K_IDLE     = 3'd1;
    localparam logic [2:0] K_ONLINE   = 3'd2;
    localparam logic [2:0] K_SCAN_MID = 3'd3;
    localparam logic [2:0] K_SCAN_END = 3'd4;
    localparam logic [2:0] K_FINISH   = 3'd5;

    logic clk_i = 1'b0;
    logic ntrst_i, tckc_i, tmsc_i, tdo_i;
    logic tmsc_o, tmsc_oen_o, tck_o, tms_o, tdi_o, online_o, nsp_o;

    logic       req;                       // Check request to the checker
    logic [2:0] req_kind;
    logic [7:0] req_arg;
    logic       exp_ntdi, exp_tms, exp_tdo;
    int         tests_passed, tests_failed;

    logic [31:0] cmds [MAX_CMDS];          // Pattern words with the command in the top byte
    int          n_cmds     = 0;
    int          limit_clks = 0;
    int          tb_errors  = 0;           // Failures outside the checker

    always #5 clk_i = ~clk_i;              // 10 ns system clock

    cjtag_bridge u_dut (
        .clk_i (clk_i), .ntrst_i (ntrst_i), .tckc_i (tckc_i), .tmsc_i (tmsc_i),
        .tmsc_o (tmsc_o), .tmsc_oen_o (tmsc_oen_o), .tck_o (tck_o), .tms_o (tms_o),
        .tdi_o (tdi_o), .tdo_i (tdo_i), .online_o (online_o), .nsp_o (nsp_o)
    );

    cjtag_checker u_checker (
        .clk_i (clk_i), .dut_tck_i (tck_o), .dut_tms_i (tms_o), .dut_tdi_i (tdi_o),
        .dut_tmsc_i (tmsc_o), .dut_tmsc_oen_i (tmsc_oen_o), .dut_online_i (online_o),
        .dut_nsp_i (nsp_o), .req_i (req), .kind_i (req_kind), .arg_i (req_arg),
        .ntdi_i (exp_ntdi), .tms_bit_i (exp_tms), .tdo_i (exp_tdo),
        .tests_passed_o (tests_passed), .tests_failed_o (tests_failed)
    );

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // Request is seen by the checker on the rising edge in between
    task automatic request_check(input logic [2:0] kind, input logic [7:0] arg);
        req_kind = kind;
        req_arg  = arg;
        req      = 1'b1;
        wait_clocks(1);
        req      = 1'b0;
    endtask

    // TMSC only changes while TCKC is low
    task automatic clock_bit(input logic value);
        tmsc_i = value;
        wait_clocks(HALF_CLKS / 2);
        tckc_i = 1'b1;
        wait_clocks(HALF_CLKS);
        tckc_i = 1'b0;
        wait_clocks(HALF_CLKS / 2);
    endtask

    // TMSC toggles once per clock while TCKC stays high
    task automatic escape_seq(input int toggles, input int high);
        tckc_i = 1'b1;
        wait_clocks(2);
        repeat (toggles) begin
            tmsc_i = ~tmsc_i;
            wait_clocks(1);
        end
        if (high > toggles + 2) wait_clocks(high - toggles - 2);
        tckc_i = 1'b0;
        wait_clocks(HALF_CLKS);
    endtask

    task automatic shift_oac(input logic [3:0] code);
        for (int b = 0; b < 4; b++) clock_bit(code[b]);   // LSB first
    endtask

    task automatic scan_packet(input logic ntdi, input logic tms, input logic tdo);
        clock_bit(ntdi);
        clock_bit(tms);
        exp_ntdi = ntdi;
        exp_tms  = tms;
        exp_tdo  = tdo;
        tmsc_i   = 1'b0;
        tdo_i    = tdo;                    // Target answer for the TDO slot
        wait_clocks(HALF_CLKS / 2);
        tckc_i = 1'b1;
        wait_clocks(HALF_CLKS - 1);
        request_check(K_SCAN_MID, 8'd0);   // Last clock before the fall
        tckc_i = 1'b0;
        wait_clocks(HALF_CLKS / 2);
        request_check(K_SCAN_END, 8'd0);
    endtask

    task automatic run_command(input logic [31:0] w);
        logic [7:0] cmd;
        cmd = w[31:24];
        case (cmd)
            C_TEST:   request_check(K_TEST, w[23:16]);
            C_ESCAPE: escape_seq(int'(w[23:16]), int'(w[15:8]));
            C_OAC:    shift_oac(w[19:16]);
            C_PACKET: scan_packet(w[16], w[8], w[0]);
            C_ONLINE: begin
                request_check(K_ONLINE, w[23:16]);
                if (w[16] == 1'b0) begin
                    // A link that is really offline drops a valid activation code
                    shift_oac(`CJTAG_OAC_VALUE);
                    request_check(K_ONLINE, w[23:16]);
                end
            end
            C_IDLE:   request_check(K_IDLE, 8'd0);
            default: begin
                $display("Pattern file has an unknown command %h", cmd);
                tb_errors++;
            end
        endcase
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        ntrst_i  = 1'b0;
        tckc_i   = 1'b0;
        tmsc_i   = 1'b0;
        tdo_i    = 1'b0;
        req      = 1'b0;
        req_kind = K_TEST;
        req_arg  = 8'd0;
        exp_ntdi = 1'b0;
        exp_tms  = 1'b0;
        exp_tdo  = 1'b0;
        for (int a = 0; a < MAX_CMDS; a++) cmds[a] = {C_END, 24'(a)};
        $readmemh("verif/cjtag_patterns.txt", cmds);
        while (n_cmds < MAX_CMDS && cmds[n_cmds][31:24] != C_END) n_cmds++;
        limit_clks = n_cmds * CLKS_PER_CMD;
        wait_clocks(2);                    // Reset held for 2 cycles
        ntrst_i = 1'b1;
        wait_clocks(4);
        for (int i = 0; i < n_cmds; i++) run_command(cmds[i]);
        request_check(K_FINISH, 8'd0);
        wait_clocks(1);
        if (tests_passed + tests_failed == 0) begin
            $display("No test ran, the pattern file is missing or empty");
            tb_errors++;
        end
        if (tb_errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized by the number of pattern lines
    initial begin
        wait (limit_clks != 0);
        repeat (limit_clks) @(posedge clk_i);
        $display("Timeout, stimulus did not finish within %0d clocks", limit_clks);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/cjtag_link_pkg.sv
hdl/oscan1_pkg.sv
hdl/cjtag_edge_if.sv
hdl/cjtag_edge_detect.sv
hdl/cjtag_escape_detect.sv
hdl/cjtag_link_fsm.sv
hdl/oscan1_packet.sv
hdl/cjtag_bridge.sv
verif/cjtag_checker.sv
verif/tb_cjtag_bridge.sv
